/* common/ht_ctrl_pkg.sv */
/*
 * Control types of the hash-table write unit: the controller states
 * and the slot choice passed from the matcher to the updater.
 */
package ht_ctrl_pkg;

	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_RDCMD   = 3'd1,
		S_RDDATA  = 3'd2,
		S_MATCH   = 3'd3,
		S_DECIDE  = 3'd4,
		S_COMMIT  = 3'd5,
		S_WIPE    = 3'd6,
		S_SENDOUT = 3'd7
	} ht_state_e;

	// which slot a write goes to
	typedef enum logic [1:0] {
		SEL_HIT   = 2'd0,
		SEL_EMPTY = 2'd1,
		SEL_EVICT = 2'd2
	} ht_slot_sel_e;

endpackage

/* common/ht_macros.svh */
/*
 * Hash-table write unit widths.
 * A line holds four slots, low slot first. Inside a slot the fields
 * run from low to high as key, value pointer, value size.
 */
`ifndef HT_MACROS_SVH
`define HT_MACROS_SVH

// request and slot fields
`define HT_KEY_W  64
`define HT_PTR_W  32
`define HT_SIZE_W 16
`define HT_SLOT_W (`HT_KEY_W + `HT_PTR_W + `HT_SIZE_W)

// memory line whose bits above the slots stay zero
`define HT_SLOTS  4
`define HT_LINE_W 512

// bucket address and slot index
`define HT_ADDR_W 8
`define HT_IDX_W  2

`endif

/* common/ht_req_pkg.sv */
/*
 * Request-side types of the hash-table write unit:
 * the opcode carried by each request and the status in its response.
 */
package ht_req_pkg;

	typedef enum logic [3:0] {
		OP_GET    = 4'h0,
		OP_SETCUR = 4'h1,
		OP_DELCUR = 4'h2,
		OP_IGNORE = 4'h3,
		OP_FLUSH  = 4'h4
	} ht_op_e;

	// evict means slot 0 of a full line was overwritten
	typedef enum logic [1:0] {
		ST_OK    = 2'd0,
		ST_MISS  = 2'd1,
		ST_EVICT = 2'd2
	} ht_status_e;

endpackage

/* dv/ht_write_tb.sv */
/*
 * Testbench of the hash-table write unit.
 * Sends directed and seeded random requests, plays the memory, free
 * and response sides under random back-pressure and checks every
 * transfer against a table model kept in the testbench.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_write_tb import ht_req_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int N_DIRECTED = 14;
	localparam int N_RANDOM = 300;
	localparam int N_FLUSH = 2;
	localparam int N_REQ = N_DIRECTED + N_RANDOM + N_FLUSH;
	localparam int LIMIT_CYCLES = N_REQ * 400 + N_FLUSH * 2000;
	localparam int N_LINES = 1 << `HT_ADDR_W;

	typedef struct packed {
		logic [`HT_ADDR_W-1:0] addr;
		logic [`HT_LINE_W-1:0] line;
	} wr_t;

	typedef struct packed {
		logic                  wipe;
		logic [`HT_PTR_W-1:0]  ptr;
		logic [`HT_SIZE_W-1:0] size;
	} free_t;

	typedef struct packed {
		ht_op_e                op;
		logic [`HT_KEY_W-1:0]  key;
		logic [`HT_PTR_W-1:0]  ptr;
		logic [`HT_SIZE_W-1:0] size;
		ht_status_e            status;
	} resp_t;

	logic                  clk;
	logic                  rst_regd;
	logic                  req_valid;
	ht_op_e                req_op;
	logic [`HT_KEY_W-1:0]  req_key;
	logic [`HT_ADDR_W-1:0] req_addr;
	logic [`HT_PTR_W-1:0]  req_ptr;
	logic [`HT_SIZE_W-1:0] req_size;
	logic                  req_ready;
	logic                  rdcmd_valid;
	logic [`HT_ADDR_W-1:0] rdcmd_addr;
	logic                  rdcmd_ready;
	logic                  rd_valid;
	logic [`HT_LINE_W-1:0] rd_line;
	logic                  rd_ready;
	logic                  wr_valid;
	logic [`HT_ADDR_W-1:0] wr_addr;
	logic [`HT_LINE_W-1:0] wr_line;
	logic                  wr_ready;
	logic                  free_valid;
	logic [`HT_PTR_W-1:0]  free_ptr;
	logic [`HT_SIZE_W-1:0] free_size;
	logic                  free_wipe;
	logic                  free_ready;
	logic                  out_valid;
	ht_op_e                out_op;
	logic [`HT_KEY_W-1:0]  out_key;
	logic [`HT_PTR_W-1:0]  out_ptr;
	logic [`HT_SIZE_W-1:0] out_size;
	ht_status_e            out_status;
	logic                  out_ready;

	// memory side and reference table
	logic [`HT_LINE_W-1:0] mem [N_LINES];
	logic [`HT_LINE_W-1:0] ref_line [N_LINES];
	logic [`HT_ADDR_W-1:0] used_addr [4] = '{8'h03, 8'h41, 8'h9c, 8'hff};

	logic [`HT_ADDR_W-1:0] exp_rd [$];
	wr_t                   exp_wr [$];
	free_t                 exp_free [$];
	resp_t                 exp_out [$];

	integer                seed = 32'h64c3;
	integer                bp_seed;
	int                    issued;
	int                    out_seen;
	logic                  rd_pending;
	logic [`HT_ADDR_W-1:0] rd_addr_q;
	logic [31:0]           rnd;
	wr_t                   wr_e;
	free_t                 free_e;
	resp_t                 resp_e;

	ht_write_top uut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------------------------------------
	// checking helpers

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("Regression failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_eq(input string name, input logic [`HT_LINE_W-1:0] got,
		input logic [`HT_LINE_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Regression failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [`HT_KEY_W-1:0] pool_key(input int idx);
		pool_key = 64'h9e37_79b9_7f4a_7c15 * (idx + 1);
	endfunction

	// ----------------------------------------------------------------------
	// table model that queues every transfer a request must cause

	task automatic apply_model(input ht_op_e op, input logic [`HT_KEY_W-1:0] key,
		input logic [`HT_ADDR_W-1:0] addr, input logic [`HT_PTR_W-1:0] ptr,
		input logic [`HT_SIZE_W-1:0] size);
		logic [`HT_LINE_W-1:0] ln;
		logic [`HT_SLOT_W-1:0] s;
		logic [`HT_PTR_W-1:0]  optr;
		logic [`HT_SIZE_W-1:0] osize;
		logic                  do_wr;
		int                    hit_i;
		int                    emp_i;
		int                    tgt;
		resp_t                 r;

		r.op = op;
		r.key = key;
		r.ptr = '0;
		r.size = '0;
		r.status = ST_OK;
		do_wr = 1'b0;
		if (op == OP_FLUSH) begin
			exp_free.push_back('{1'b1, {`HT_PTR_W{1'b0}}, {`HT_SIZE_W{1'b0}}});
			for (int a = 0; a < N_LINES; a++) begin
				exp_wr.push_back('{a[`HT_ADDR_W-1:0], {`HT_LINE_W{1'b0}}});
				ref_line[a] = '0;
			end
		end else if (op == OP_IGNORE) begin
			r.size = size;
		end else begin
			exp_rd.push_back(addr);
			ln = ref_line[addr];
			hit_i = -1;
			emp_i = -1;
			for (int i = 0; i < `HT_SLOTS; i++) begin
				s = ln[i*`HT_SLOT_W +: `HT_SLOT_W];
				if (s[`HT_KEY_W-1:0] == key) begin
					hit_i = i;
				end
				if (s[`HT_KEY_W-1:0] == '0) begin
					emp_i = i;
				end
			end
			// a full line gives up slot 0
			tgt = (hit_i >= 0) ? hit_i : ((emp_i >= 0) ? emp_i : 0);
			s = ln[tgt*`HT_SLOT_W +: `HT_SLOT_W];
			optr = s[`HT_KEY_W +: `HT_PTR_W];
			osize = s[`HT_KEY_W+`HT_PTR_W +: `HT_SIZE_W];
			case (op)
				OP_GET: begin
					if (hit_i >= 0) begin
						r.ptr = optr;
						r.size = osize;
					end else begin
						r.status = ST_MISS;
					end
				end
				OP_SETCUR: begin
					if ((hit_i >= 0 || emp_i < 0) && optr != '0) begin
						exp_free.push_back('{1'b0, optr, osize});
					end
					if (hit_i < 0 && emp_i < 0) begin
						r.status = ST_EVICT;
					end
					ln[tgt*`HT_SLOT_W +: `HT_SLOT_W] = {size, ptr, key};
					r.ptr = ptr;
					r.size = size;
					do_wr = 1'b1;
				end
				default: begin
					if (hit_i >= 0) begin
						if (optr != '0) begin
							exp_free.push_back('{1'b0, optr, osize});
						end
						ln[tgt*`HT_SLOT_W +: `HT_SLOT_W] = '0;
						do_wr = 1'b1;
					end else begin
						r.status = ST_MISS;
					end
				end
			endcase
			if (do_wr) begin
				ln[`HT_LINE_W-1:`HT_SLOTS*`HT_SLOT_W] = '0;
				exp_wr.push_back('{addr, ln});
				ref_line[addr] = ln;
			end
		end
		exp_out.push_back(r);
	endtask

	// ----------------------------------------------------------------------
	// request driver called and returning 2 ns after a rising edge

	task automatic send_request(input ht_op_e op, input int kidx, input int aidx);
		logic [`HT_PTR_W-1:0]  ptr;
		logic [`HT_SIZE_W-1:0] size;

		ptr = $random(seed);
		if (ptr == '0) begin
			ptr = 1;
		end
		size = $random(seed);
		apply_model(op, pool_key(kidx), used_addr[aidx], ptr, size);
		req_valid = 1'b1;
		req_op = op;
		req_key = pool_key(kidx);
		req_addr = used_addr[aidx];
		req_ptr = ptr;
		req_size = size;
		issued++;
		do begin
			@(posedge clk);
		end while (!req_ready);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (out_seen != issued || exp_rd.size() != 0 || exp_wr.size() != 0 ||
			exp_free.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_wiped();
		for (int a = 0; a < N_LINES; a++) begin
			check_eq("flushed memory line", mem[a], '0);
		end
	endtask

	// ----------------------------------------------------------------------
	// environment monitors transfers at the edge and drives 2 ns later

	always @(posedge clk) begin
		if (!rst_regd) begin
			if (rdcmd_valid && rdcmd_ready) begin
				if (exp_rd.size() == 0) begin
					abort_run("read command issued although none was expected");
				end else begin
					check_eq("rdcmd_addr", rdcmd_addr, exp_rd.pop_front());
					rd_pending = 1'b1;
					rd_addr_q = rdcmd_addr;
				end
			end
			if (rd_valid && rd_ready) begin
				rd_pending = 1'b0;
			end
			if (wr_valid && wr_ready) begin
				if (exp_wr.size() == 0) begin
					abort_run("line written although no write was expected");
				end else begin
					wr_e = exp_wr.pop_front();
					check_eq("wr_addr", wr_addr, wr_e.addr);
					check_eq("wr_line", wr_line, wr_e.line);
					mem[wr_addr] = wr_line;
				end
			end
			if (free_valid && free_ready) begin
				if (exp_free.size() == 0) begin
					abort_run("value freed although no free was expected");
				end else begin
					free_e = exp_free.pop_front();
					check_eq("free_wipe", free_wipe, free_e.wipe);
					check_eq("free_ptr", free_ptr, free_e.ptr);
					check_eq("free_size", free_size, free_e.size);
				end
			end
			if (out_valid && out_ready) begin
				if (exp_out.size() == 0) begin
					abort_run("response sent although none was expected");
				end else begin
					resp_e = exp_out.pop_front();
					check_eq("out_op", out_op, resp_e.op);
					check_eq("out_key", out_key, resp_e.key);
					check_eq("out_ptr", out_ptr, resp_e.ptr);
					check_eq("out_size", out_size, resp_e.size);
					check_eq("out_status", out_status, resp_e.status);
					out_seen++;
				end
			end

			#2;
			rnd = $random(bp_seed);
			rdcmd_ready = rnd[0] | rnd[4];
			wr_ready = rnd[1] | rnd[5];
			free_ready = rnd[2] | rnd[6];
			out_ready = rnd[3] | rnd[7];
			if (!rd_pending) begin
				rd_valid = 1'b0;
			end else if (!rd_valid && rnd[8]) begin
				rd_valid = 1'b1;
				rd_line = mem[rd_addr_q];
			end
		end
	end

	initial begin
		#(CLK_PERIOD * LIMIT_CYCLES);
		abort_run("watchdog expired before all requests completed");
	end

	// ----------------------------------------------------------------------
	// main sequence

	initial begin
		ht_op_e op;
		int     pick;

		clk = 1'b0;
		rst_regd = 1'b1;
		req_valid = 1'b0;
		req_op = OP_GET;
		req_key = '0;
		req_addr = '0;
		req_ptr = '0;
		req_size = '0;
		rdcmd_ready = 1'b0;
		rd_valid = 1'b0;
		rd_line = '0;
		wr_ready = 1'b0;
		free_ready = 1'b0;
		out_ready = 1'b0;
		issued = 0;
		out_seen = 0;
		rd_pending = 1'b0;
		bp_seed = $random(seed);
		// unused lines carry a pattern so the flush has something to wipe
		for (int a = 0; a < N_LINES; a++) begin
			mem[a] = {(`HT_LINE_W/8){a[7:0] ^ 8'ha5}};
		end
		for (int i = 0; i < 4; i++) begin
			mem[used_addr[i]] = '0;
		end
		for (int a = 0; a < N_LINES; a++) begin
			ref_line[a] = mem[a];
		end

		repeat (3) @(posedge clk);
		#2;
		rst_regd = 1'b0;

		// insert, replace, delete and miss on one key
		send_request(OP_SETCUR, 0, 0);
		send_request(OP_GET, 0, 0);
		send_request(OP_SETCUR, 0, 0);
		send_request(OP_GET, 0, 0);
		send_request(OP_DELCUR, 0, 0);
		send_request(OP_GET, 0, 0);
		send_request(OP_DELCUR, 0, 0);
		// fill a line, then evict slot 0
		send_request(OP_SETCUR, 1, 1);
		send_request(OP_SETCUR, 2, 1);
		send_request(OP_SETCUR, 3, 1);
		send_request(OP_SETCUR, 4, 1);
		send_request(OP_SETCUR, 5, 1);
		send_request(OP_GET, 4, 1);
		send_request(OP_IGNORE, 6, 2);

		for (int i = 0; i < N_RANDOM; i++) begin
			if (i == 100 || i == 200) begin
				send_request(OP_FLUSH, i % 12, 0);
				wait_drained();
				check_wiped();
			end
			pick = $unsigned($random(seed)) % 20;
			if (pick < 7) begin
				op = OP_GET;
			end else if (pick < 14) begin
				op = OP_SETCUR;
			end else if (pick < 18) begin
				op = OP_DELCUR;
			end else begin
				op = OP_IGNORE;
			end
			send_request(op, $unsigned($random(seed)) % 12, $unsigned($random(seed)) % 4);
		end

		wait_drained();
		// late stray transfers would still be caught here
		repeat (20) @(posedge clk);
		for (int a = 0; a < N_LINES; a++) begin
			check_eq("memory line", mem[a], ref_line[a]);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
common/ht_req_pkg.sv
common/ht_ctrl_pkg.sv
logic/ht_wipe_counter.sv
ht_write/ht_bucket_match.sv
ht_write/ht_entry_update.sv
ht_write/ht_ctrl_fsm.sv
ht_write/ht_write_top.sv
dv/ht_write_tb.sv

/* ht_write/ht_bucket_match.sv */
/*
 * Bucket matcher. Compares every slot key of the read line with the
 * request key and registers hit, slot indexes and the slot choice.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_bucket_match import ht_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  logic                  line_valid,
	input  logic [`HT_LINE_W-1:0] line,
	input  logic [`HT_KEY_W-1:0]  key_q,
	output logic                  hit,
	output logic [`HT_IDX_W-1:0]  hit_idx,
	output logic [`HT_IDX_W-1:0]  empty_idx,
	output ht_slot_sel_e          sel
);

	logic [`HT_SLOTS-1:0] match_v;
	logic [`HT_SLOTS-1:0] empty_v;
	logic [`HT_IDX_W-1:0] match_idx;
	logic [`HT_IDX_W-1:0] free_idx;

	// later slots win, so free_idx ends on the highest empty slot
	always_comb begin
		match_idx = '0;
		free_idx = '0;
		for (int i = 0; i < `HT_SLOTS; i++) begin
			match_v[i] = (key_q != '0) && (line[i*`HT_SLOT_W +: `HT_KEY_W] == key_q);
			empty_v[i] = (line[i*`HT_SLOT_W +: `HT_KEY_W] == '0);
			if (match_v[i]) begin
				match_idx = i[`HT_IDX_W-1:0];
			end
			if (empty_v[i]) begin
				free_idx = i[`HT_IDX_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			hit <= 1'b0;
			sel <= SEL_EVICT;
		end else if (line_valid) begin
			hit <= |match_v;
			if (|match_v) begin
				sel <= SEL_HIT;
			end else if (|empty_v) begin
				sel <= SEL_EMPTY;
			end else begin
				sel <= SEL_EVICT;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_valid) begin
			hit_idx <= match_idx;
			empty_idx <= free_idx;
		end
	end

	a_unique_key: assert property (@(posedge clk) disable iff (rst_regd)
		line_valid |-> $onehot0(match_v))
		else $error("key stored in more than one slot");

endmodule

/* ht_write/ht_ctrl_fsm.sv */
/*
 * Request controller of the hash-table write unit.
 * Takes one request at a time, reads its bucket line, registers the
 * decision of the updater and drives the write, free and response
 * handshakes. A flush walks every line and writes zeros.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_ctrl_fsm import ht_req_pkg::*, ht_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  logic                  req_valid,
	input  ht_op_e                req_op,
	input  logic [`HT_KEY_W-1:0]  req_key,
	input  logic [`HT_ADDR_W-1:0] req_addr,
	input  logic [`HT_PTR_W-1:0]  req_ptr,
	input  logic [`HT_SIZE_W-1:0] req_size,
	output logic                  req_ready,
	output logic                  rdcmd_valid,
	output logic [`HT_ADDR_W-1:0] rdcmd_addr,
	input  logic                  rdcmd_ready,
	input  logic                  rd_valid,
	input  logic [`HT_LINE_W-1:0] rd_line,
	output logic                  rd_ready,
	output logic                  wr_valid,
	output logic [`HT_ADDR_W-1:0] wr_addr,
	output logic [`HT_LINE_W-1:0] wr_line,
	input  logic                  wr_ready,
	output logic                  free_valid,
	output logic [`HT_PTR_W-1:0]  free_ptr,
	output logic [`HT_SIZE_W-1:0] free_size,
	output logic                  free_wipe,
	input  logic                  free_ready,
	output logic                  out_valid,
	output ht_op_e                out_op,
	output logic [`HT_KEY_W-1:0]  out_key,
	output logic [`HT_PTR_W-1:0]  out_ptr,
	output logic [`HT_SIZE_W-1:0] out_size,
	output ht_status_e            out_status,
	input  logic                  out_ready,
	input  logic                  hit,
	input  ht_slot_sel_e          sel,
	input  logic [`HT_LINE_W-1:0] new_line,
	input  logic                  free_needed,
	input  logic [`HT_PTR_W-1:0]  free_ptr_n,
	input  logic [`HT_SIZE_W-1:0] free_size_n,
	input  logic [`HT_PTR_W-1:0]  resp_ptr,
	input  logic [`HT_SIZE_W-1:0] resp_size,
	input  ht_status_e            resp_status,
	input  logic [`HT_ADDR_W-1:0] wipe_addr,
	input  logic                  wipe_done,
	output logic                  line_valid,
	output logic [`HT_LINE_W-1:0] line,
	output logic [`HT_KEY_W-1:0]  key_q,
	output ht_op_e                op_q,
	output logic [`HT_PTR_W-1:0]  ptr_q,
	output logic [`HT_SIZE_W-1:0] size_q,
	output logic                  wipe_start,
	output logic                  wipe_step
);

	ht_state_e state;
	// set once the transfers of the current phase have been raised
	logic      issued;
	logic      need_free_q;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= S_IDLE;
			req_ready <= 1'b0;
			rdcmd_valid <= 1'b0;
			rd_ready <= 1'b0;
			wr_valid <= 1'b0;
			free_valid <= 1'b0;
			free_wipe <= 1'b0;
			out_valid <= 1'b0;
			line_valid <= 1'b0;
			wipe_start <= 1'b0;
			wipe_step <= 1'b0;
			issued <= 1'b0;
			need_free_q <= 1'b0;
		end else begin
			// one-cycle pulses
			req_ready <= 1'b0;
			rd_ready <= 1'b0;
			line_valid <= 1'b0;
			wipe_start <= 1'b0;
			wipe_step <= 1'b0;

			// completed transfers drop their valid
			if (rdcmd_valid && rdcmd_ready) begin
				rdcmd_valid <= 1'b0;
			end
			if (wr_valid && wr_ready) begin
				wr_valid <= 1'b0;
			end
			if (free_valid && free_ready) begin
				free_valid <= 1'b0;
				free_wipe <= 1'b0;
			end
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end

			case (state)
				S_IDLE: begin
					if (req_valid) begin
						req_ready <= 1'b1;
						op_q <= req_op;
						key_q <= req_key;
						ptr_q <= req_ptr;
						size_q <= req_size;
						rdcmd_addr <= req_addr;
						wr_addr <= req_addr;
						out_op <= req_op;
						out_key <= req_key;
						case (req_op)
							OP_IGNORE: state <= S_SENDOUT;
							OP_FLUSH: begin
								// announce the wipe before touching memory
								free_valid <= 1'b1;
								free_wipe <= 1'b1;
								free_ptr <= '0;
								free_size <= '0;
								wipe_start <= 1'b1;
								state <= S_WIPE;
							end
							default: state <= S_RDCMD;
						endcase
					end
				end

				S_RDCMD: begin
					if (!rdcmd_valid) begin
						rdcmd_valid <= 1'b1;
					end else if (rdcmd_ready) begin
						state <= S_RDDATA;
					end
				end

				S_RDDATA: begin
					if (rd_valid) begin
						rd_ready <= 1'b1;
						line <= rd_line;
						line_valid <= 1'b1;
						state <= S_MATCH;
					end
				end

				// matcher registers its result this cycle
				S_MATCH: state <= S_DECIDE;

				S_DECIDE: begin
					wr_line <= new_line;
					free_ptr <= free_ptr_n;
					free_size <= free_size_n;
					need_free_q <= free_needed;
					if (op_q == OP_SETCUR || (op_q == OP_DELCUR && hit)) begin
						state <= S_COMMIT;
					end else begin
						state <= S_SENDOUT;
					end
				end

				S_COMMIT: begin
					if (!issued) begin
						if (wr_ready && out_ready && (free_ready || !need_free_q)) begin
							wr_valid <= 1'b1;
							free_valid <= need_free_q;
							out_valid <= 1'b1;
							out_ptr <= resp_ptr;
							out_size <= resp_size;
							out_status <= resp_status;
							issued <= 1'b1;
						end
					end else if (!wr_valid && !free_valid && !out_valid) begin
						issued <= 1'b0;
						state <= S_IDLE;
					end
				end

				S_WIPE: begin
					if (!wr_valid && !free_valid) begin
						if (wipe_done) begin
							state <= S_SENDOUT;
						end else begin
							wr_valid <= 1'b1;
							wr_addr <= wipe_addr;
							wr_line <= '0;
							wipe_step <= 1'b1;
						end
					end
				end

				S_SENDOUT: begin
					if (!issued) begin
						if (out_ready) begin
							out_valid <= 1'b1;
							out_ptr <= resp_ptr;
							out_size <= resp_size;
							out_status <= resp_status;
							issued <= 1'b1;
						end
					end else if (!out_valid) begin
						issued <= 1'b0;
						state <= S_IDLE;
					end
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// checks

	a_out_hold: assert property (@(posedge clk) disable iff (rst_regd)
		out_valid && !out_ready |=> out_valid &&
			$stable({out_op, out_key, out_ptr, out_size, out_status}))
		else $error("response changed before out_ready");

	a_no_wr_idle: assert property (@(posedge clk) disable iff (rst_regd)
		state == S_IDLE |-> !wr_valid)
		else $error("write pending while idle");

endmodule

/* ht_write/ht_entry_update.sv */
/*
 * Slot updater. Applies the opcode rules to the read line and gives
 * the rewritten line, the value to free and the response fields.
 * Purely combinational.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_entry_update import ht_req_pkg::*, ht_ctrl_pkg::*; (
	input  logic [`HT_LINE_W-1:0] line,
	input  ht_op_e                op_q,
	input  logic [`HT_KEY_W-1:0]  key_q,
	input  logic [`HT_PTR_W-1:0]  ptr_q,
	input  logic [`HT_SIZE_W-1:0] size_q,
	input  logic [`HT_IDX_W-1:0]  hit_idx,
	input  logic [`HT_IDX_W-1:0]  empty_idx,
	input  ht_slot_sel_e          sel,
	output logic [`HT_LINE_W-1:0] new_line,
	output logic                  free_needed,
	output logic [`HT_PTR_W-1:0]  free_ptr_n,
	output logic [`HT_SIZE_W-1:0] free_size_n,
	output logic [`HT_PTR_W-1:0]  resp_ptr,
	output logic [`HT_SIZE_W-1:0] resp_size,
	output ht_status_e            resp_status
);

	logic [`HT_IDX_W-1:0]  idx;
	logic [`HT_SLOT_W-1:0] cur_slot;
	logic [`HT_PTR_W-1:0]  cur_ptr;
	logic [`HT_SIZE_W-1:0] cur_size;

	// target slot is the hit, else the highest empty one, else slot 0
	always_comb begin
		case (sel)
			SEL_HIT:   idx = hit_idx;
			SEL_EMPTY: idx = empty_idx;
			default:   idx = '0;
		endcase
		cur_slot = line[idx*`HT_SLOT_W +: `HT_SLOT_W];
		cur_ptr = cur_slot[`HT_KEY_W +: `HT_PTR_W];
		cur_size = cur_slot[`HT_KEY_W+`HT_PTR_W +: `HT_SIZE_W];
	end

	always_comb begin
		new_line = line;
		free_needed = 1'b0;
		free_ptr_n = cur_ptr;
		free_size_n = cur_size;
		resp_ptr = '0;
		resp_size = '0;
		resp_status = ST_OK;

		case (op_q)
			OP_GET: begin
				if (sel == SEL_HIT) begin
					resp_ptr = cur_ptr;
					resp_size = cur_size;
				end else begin
					resp_status = ST_MISS;
				end
			end

			OP_SETCUR: begin
				new_line[idx*`HT_SLOT_W +: `HT_SLOT_W] = {size_q, ptr_q, key_q};
				// an old value in the slot is released
				free_needed = (sel != SEL_EMPTY) && (cur_ptr != '0);
				resp_ptr = ptr_q;
				resp_size = size_q;
				if (sel == SEL_EVICT) begin
					resp_status = ST_EVICT;
				end
			end

			OP_DELCUR: begin
				if (sel == SEL_HIT) begin
					new_line[idx*`HT_SLOT_W +: `HT_SLOT_W] = '0;
					free_needed = (cur_ptr != '0);
				end else begin
					resp_status = ST_MISS;
				end
			end

			OP_IGNORE: resp_size = size_q;

			// flush answers with zeros
			default: resp_status = ST_OK;
		endcase

		new_line[`HT_LINE_W-1:`HT_SLOTS*`HT_SLOT_W] = '0;
	end

endmodule

/* ht_write/ht_write_top.sv */
/*
 * Hash-table write unit.
 * Reads the bucket line of each request, matches the key against all
 * slots, rewrites the line, frees displaced values and answers once.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_write_top import ht_req_pkg::*, ht_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  logic                  req_valid,
	input  ht_op_e                req_op,
	input  logic [`HT_KEY_W-1:0]  req_key,
	input  logic [`HT_ADDR_W-1:0] req_addr,
	input  logic [`HT_PTR_W-1:0]  req_ptr,
	input  logic [`HT_SIZE_W-1:0] req_size,
	output logic                  req_ready,
	output logic                  rdcmd_valid,
	output logic [`HT_ADDR_W-1:0] rdcmd_addr,
	input  logic                  rdcmd_ready,
	input  logic                  rd_valid,
	input  logic [`HT_LINE_W-1:0] rd_line,
	output logic                  rd_ready,
	output logic                  wr_valid,
	output logic [`HT_ADDR_W-1:0] wr_addr,
	output logic [`HT_LINE_W-1:0] wr_line,
	input  logic                  wr_ready,
	output logic                  free_valid,
	output logic [`HT_PTR_W-1:0]  free_ptr,
	output logic [`HT_SIZE_W-1:0] free_size,
	output logic                  free_wipe,
	input  logic                  free_ready,
	output logic                  out_valid,
	output ht_op_e                out_op,
	output logic [`HT_KEY_W-1:0]  out_key,
	output logic [`HT_PTR_W-1:0]  out_ptr,
	output logic [`HT_SIZE_W-1:0] out_size,
	output ht_status_e            out_status,
	input  logic                  out_ready
);

	// ---------------------------------------------------------------------
	// matcher to updater
	logic                  hit;
	logic [`HT_IDX_W-1:0]  hit_idx;
	logic [`HT_IDX_W-1:0]  empty_idx;
	ht_slot_sel_e          sel;

	// updater to controller
	logic [`HT_LINE_W-1:0] new_line;
	logic                  free_needed;
	logic [`HT_PTR_W-1:0]  free_ptr_n;
	logic [`HT_SIZE_W-1:0] free_size_n;
	logic [`HT_PTR_W-1:0]  resp_ptr;
	logic [`HT_SIZE_W-1:0] resp_size;
	ht_status_e            resp_status;

	// controller outputs, registered request and read line
	logic                  line_valid;
	logic [`HT_LINE_W-1:0] line;
	logic [`HT_KEY_W-1:0]  key_q;
	ht_op_e                op_q;
	logic [`HT_PTR_W-1:0]  ptr_q;
	logic [`HT_SIZE_W-1:0] size_q;

	// flush address walk
	logic                  wipe_start;
	logic                  wipe_step;
	logic [`HT_ADDR_W-1:0] wipe_addr;
	logic                  wipe_done;
	// ---------------------------------------------------------------------

	ht_ctrl_fsm u_ctrl (.*);

	ht_bucket_match u_match (.*);

	ht_entry_update u_update (.*);

	ht_wipe_counter u_wipe (.*);

endmodule

/* logic/ht_wipe_counter.sv */
/*
 * Flush address counter. Restarts at line 0 on wipe_start, steps one
 * line per wipe_step and flags done once the last line is stepped.
 */
`timescale 1ns/100ps
`include "ht_macros.svh"

module ht_wipe_counter (
	input  logic                  clk,
	input  logic                  rst_regd,
	input  logic                  wipe_start,
	input  logic                  wipe_step,
	output logic [`HT_ADDR_W-1:0] wipe_addr,
	output logic                  wipe_done
);

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			wipe_addr <= '0;
			wipe_done <= 1'b0;
		end else if (wipe_start) begin
			wipe_addr <= '0;
			wipe_done <= 1'b0;
		end else if (wipe_step) begin
			// hold on the last line
			if (wipe_addr == '1) begin
				wipe_done <= 1'b1;
			end else begin
				wipe_addr <= wipe_addr + 1'b1;
			end
		end
	end

	a_no_step_done: assert property (@(posedge clk) disable iff (rst_regd)
		wipe_step |-> !wipe_done)
		else $error("wipe stepped past the last line");

endmodule
